// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= menu_tb
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Done: no errors
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
SIM_ARGS   ?= +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q -x -F "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== background/background_render.sv ====
`default_nettype none

`include "menu_defines.svh"

module background_render (
  input  logic                    pclk,
  input  logic                    rst,
  input  menu_pkg::screen_mode_e  mode,
  vga_if.sink                     vga_in,
  vga_if.source                   vga_out,
  output menu_pkg::rgb_t          rgb
);

  import menu_pkg::*;

  rgb_t rgb_nxt;
  logic [11:0] h;
  logic [11:0] v;

  assign h = vga_in.hcount;
  assign v = vga_in.vcount;

  // Open on the left and top, closed on the right and bottom.
  function automatic logic in_rect(input logic [11:0] hc, input logic [11:0] vc,
                                   input int x0, input int x1, input int y0, input int y1);
    return (int'(hc) > x0) && (int'(hc) <= x1) && (int'(vc) > y0) && (int'(vc) <= y1);
  endfunction

  function automatic logic menu_letters(input logic [11:0] hc, input logic [11:0] vc);
    logic m_hit;
    logic e_hit;
    logic n_hit;
    logic u_hit;
    m_hit = in_rect(hc, vc, 170, 210, 90, 250) || in_rect(hc, vc, 170, 370, 50, 90) ||
            in_rect(hc, vc, 250, 290, 90, 250) || in_rect(hc, vc, 330, 370, 90, 250);
    e_hit = in_rect(hc, vc, 420, 460, 50, 250) || in_rect(hc, vc, 460, 500, 50, 90) ||
            in_rect(hc, vc, 460, 500, 130, 170) || in_rect(hc, vc, 460, 500, 210, 250);
    n_hit = in_rect(hc, vc, 550, 590, 90, 250) || in_rect(hc, vc, 550, 670, 50, 90) ||
            in_rect(hc, vc, 630, 670, 90, 250);
    u_hit = in_rect(hc, vc, 720, 760, 50, 210) || in_rect(hc, vc, 720, 840, 210, 250) ||
            in_rect(hc, vc, 800, 840, 50, 210);
    return m_hit || e_hit || n_hit || u_hit;
  endfunction

  // White frame just outside the playfield.
  function automatic logic game_frame(input logic [11:0] hc, input logic [11:0] vc);
    int hi;
    int vi;
    logic rows;
    hi   = int'(hc);
    vi   = int'(vc);
    rows = (vi >= `TOP_LINE - `BORDER) && (vi < `BOTTOM_LINE + `BORDER);
    return (rows && hi >= `LEFT_LINE - `BORDER && hi < `LEFT_LINE) ||
           (rows && hi >= `RIGHT_LINE && hi < `RIGHT_LINE + `BORDER) ||
           (hi >= `LEFT_LINE && hi < `RIGHT_LINE && vi >= `TOP_LINE - `BORDER &&
            vi < `TOP_LINE) ||
           (hi >= `LEFT_LINE && hi < `RIGHT_LINE && vi >= `BOTTOM_LINE &&
            vi < `BOTTOM_LINE + `BORDER);
  endfunction

  always_comb begin
    rgb_nxt = '0;
    if (!(vga_in.hblnk || vga_in.vblnk)) begin
      case (mode)
        MENU_MODE, GAME_MODE: begin
          if (v == 12'd0)                            rgb_nxt = `EDGE_TOP_RGB;
          else if (v == 12'(`V_ACTIVE - 1))          rgb_nxt = `EDGE_BOTTOM_RGB;
          else if (h == 12'd0)                       rgb_nxt = `EDGE_LEFT_RGB;
          else if (h == 12'(`H_ACTIVE - 1))          rgb_nxt = `EDGE_RIGHT_RGB;
          else if (mode == MENU_MODE && menu_letters(h, v)) rgb_nxt = `LETTER_RGB;
          else if (mode == GAME_MODE && game_frame(h, v))   rgb_nxt = `LETTER_RGB;
        end
        VICTORY_MODE: rgb_nxt = `VICTORY_RGB;
        GAME_OVER:    rgb_nxt = `OVER_RGB;
        MULTI_WAIT:   rgb_nxt = `WAIT_RGB;
        default:      rgb_nxt = '0;
      endcase
    end
  end

  // Colour and timing leave together, one cycle after the inputs.
  always_ff @(posedge pclk) begin
    if (rst) begin
      rgb            <= '0;
      vga_out.hcount <= '0;
      vga_out.vcount <= '0;
      vga_out.hsync  <= 1'b0;
      vga_out.vsync  <= 1'b0;
      vga_out.hblnk  <= 1'b0;
      vga_out.vblnk  <= 1'b0;
    end else begin
      rgb            <= rgb_nxt;
      vga_out.hcount <= vga_in.hcount;
      vga_out.vcount <= vga_in.vcount;
      vga_out.hsync  <= vga_in.hsync;
      vga_out.vsync  <= vga_in.vsync;
      vga_out.hblnk  <= vga_in.hblnk;
      vga_out.vblnk  <= vga_in.vblnk;
    end
  end

endmodule

`default_nettype wire

// ==== background/mode_fsm.sv ====
`default_nettype none

module mode_fsm (
  input  logic                    pclk,
  input  logic                    rst,
  input  menu_pkg::button_hits_t  hits,
  input  logic                    mouse_left,
  input  logic                    game_on,
  input  logic                    menu_on,
  input  logic                    game_over,
  input  logic                    victory,
  input  logic                    opponent_ready,
  output menu_pkg::screen_mode_e  mode,
  output logic                    play_selected,
  output logic                    display_buttons,
  output logic                    player_ready,
  output logic                    display_menu_button
);

  import menu_pkg::*;

  screen_mode_e state;
  screen_mode_e state_nxt;
  logic         click_q;

  // Button level delayed to stay in step with the registered hits.
  always_ff @(posedge pclk) begin
    if (rst) begin
      state   <= MENU_MODE;
      click_q <= 1'b0;
    end else begin
      state   <= state_nxt;
      click_q <= mouse_left;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      MENU_MODE: begin
        if (game_on)        state_nxt = GAME_MODE;
        else if (hits.play) state_nxt = GAME_MODE;
        else if (hits.multi) state_nxt = MULTI_WAIT;
        else if (game_over) state_nxt = GAME_OVER;
        else if (victory)   state_nxt = VICTORY_MODE;
      end
      GAME_MODE: begin
        if (menu_on)        state_nxt = MENU_MODE;
        else if (game_over) state_nxt = GAME_OVER;
        else if (victory)   state_nxt = VICTORY_MODE;
      end
      // Any click outside the buttons returns to the menu.
      VICTORY_MODE, GAME_OVER: begin
        if (game_on)         state_nxt = GAME_MODE;
        else if (menu_on)    state_nxt = MENU_MODE;
        else if (hits.play)  state_nxt = GAME_MODE;
        else if (hits.multi) state_nxt = MULTI_WAIT;
        else if (click_q)    state_nxt = MENU_MODE;
      end
      MULTI_WAIT: begin
        if (hits.menu)           state_nxt = MENU_MODE;
        else if (opponent_ready) state_nxt = GAME_MODE;
      end
      default: begin
        state_nxt = MENU_MODE;
      end
    endcase
  end

  assign mode                = state;
  assign play_selected       = (state == GAME_MODE);
  assign display_buttons     = (state == MENU_MODE) || (state == VICTORY_MODE) ||
                               (state == GAME_OVER);
  assign player_ready        = (state == MULTI_WAIT);
  assign display_menu_button = (state == MULTI_WAIT);

endmodule

`default_nettype wire

// ==== common/menu_defines.svh ====
`ifndef MENU_DEFINES_SVH
`define MENU_DEFINES_SVH

// XGA 1024x768 display timing.
`define H_ACTIVE    1024
`define H_FRONT     24
`define H_SYNC      136
`define H_TOTAL     1344
`define V_ACTIVE    768
`define V_FRONT     3
`define V_SYNC      6
`define V_TOTAL     806

// Button boxes, top left corner and size.
`define PLAY_X      432
`define PLAY_Y      400
`define MULTI_X     432
`define MULTI_Y     540
`define MENU_X      432
`define MENU_Y      520
`define BOX_W       128
`define BOX_H       80
`define HIT_MARGIN  10

// Playfield boundary and frame thickness.
`define TOP_LINE    317
`define BOTTOM_LINE 617
`define LEFT_LINE   361
`define RIGHT_LINE  661
`define BORDER      10

// Background colours.
`define EDGE_TOP_RGB    12'hff0
`define EDGE_BOTTOM_RGB 12'hf00
`define EDGE_LEFT_RGB   12'h0f0
`define EDGE_RIGHT_RGB  12'h00f
`define LETTER_RGB      12'hfff
`define VICTORY_RGB     12'h2f2
`define OVER_RGB        12'hf22
`define WAIT_RGB        12'h22f

`endif

// ==== common/menu_pkg.sv ====
`default_nettype none

package menu_pkg;

  // Screen modes, encoded 0 to 4.
  typedef enum logic [2:0] {
    MENU_MODE    = 3'd0,
    GAME_MODE    = 3'd1,
    VICTORY_MODE = 3'd2,
    GAME_OVER    = 3'd3,
    MULTI_WAIT   = 3'd4
  } screen_mode_e;

  // 12-bit pixel colour, 4 bits per channel.
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  // One flag per on-screen button, high while pressed inside the box.
  typedef struct packed {
    logic play;
    logic multi;
    logic menu;
  } button_hits_t;

endpackage

`default_nettype wire

// ==== common/vga_if.sv ====
`default_nettype none

interface vga_if;

  logic [11:0] hcount;
  logic [11:0] vcount;
  logic        hsync;
  logic        vsync;
  logic        hblnk;
  logic        vblnk;

  // Producer of the timing stream.
  modport source (output hcount, vcount, hsync, vsync, hblnk, vblnk);

  // Consumer of the timing stream.
  modport sink (input hcount, vcount, hsync, vsync, hblnk, vblnk);

endinterface

`default_nettype wire

// ==== hdl/button_decode.sv ====
`default_nettype none

`include "menu_defines.svh"

module button_decode (
  input  logic                    pclk,
  input  logic                    rst,
  input  logic [11:0]             xpos,
  input  logic [11:0]             ypos,
  input  logic                    mouse_left,
  output menu_pkg::button_hits_t  hits
);

  import menu_pkg::*;

  // The right edge of the hit window sits a few pixels inside the box.
  localparam int RIGHT_TRIM = 5;

  button_hits_t hits_nxt;

  function automatic logic in_box(input logic [11:0] x, input logic [11:0] y,
                                  input int bx, input int by);
    logic x_ok;
    logic y_ok;
    x_ok = (int'(x) >= bx - `HIT_MARGIN) && (int'(x) <= bx + `BOX_W - RIGHT_TRIM);
    y_ok = (int'(y) >= by - `HIT_MARGIN) && (int'(y) <= by + `BOX_H);
    return x_ok && y_ok;
  endfunction

  always_comb begin
    hits_nxt.play  = mouse_left && in_box(xpos, ypos, `PLAY_X, `PLAY_Y);
    hits_nxt.multi = mouse_left && in_box(xpos, ypos, `MULTI_X, `MULTI_Y);
    hits_nxt.menu  = mouse_left && in_box(xpos, ypos, `MENU_X, `MENU_Y);
  end

  // All three hits are registered together as one consistent set.
  always_ff @(posedge pclk) begin
    if (rst) begin
      hits <= '0;
    end else begin
      hits <= hits_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/menu_top.sv ====
`default_nettype none

module menu_top (
  input  logic                    pclk,
  input  logic                    rst,
  input  logic [11:0]             xpos,
  input  logic [11:0]             ypos,
  input  logic                    mouse_left,
  input  logic                    game_on,
  input  logic                    menu_on,
  input  logic                    game_over,
  input  logic                    victory,
  input  logic                    opponent_ready,
  output logic [11:0]             hcount,
  output logic [11:0]             vcount,
  output logic                    hsync,
  output logic                    vsync,
  output logic                    hblnk,
  output logic                    vblnk,
  output menu_pkg::rgb_t          rgb,
  output menu_pkg::screen_mode_e  mode,
  output logic                    play_selected,
  output logic                    display_buttons,
  output logic                    player_ready,
  output logic                    display_menu_button
);

  import menu_pkg::*;

  button_hits_t hits;

  // Raw timing from the generator and the copy delayed alongside the colour.
  vga_if timing_bus ();
  vga_if render_bus ();

  vga_timing vga_timing_inst (
    .pclk (pclk),
    .rst  (rst),
    .vga  (timing_bus.source)
  );

  button_decode button_decode_inst (
    .pclk       (pclk),
    .rst        (rst),
    .xpos       (xpos),
    .ypos       (ypos),
    .mouse_left (mouse_left),
    .hits       (hits)
  );

  mode_fsm mode_fsm_inst (
    .pclk                (pclk),
    .rst                 (rst),
    .hits                (hits),
    .mouse_left          (mouse_left),
    .game_on             (game_on),
    .menu_on             (menu_on),
    .game_over           (game_over),
    .victory             (victory),
    .opponent_ready      (opponent_ready),
    .mode                (mode),
    .play_selected       (play_selected),
    .display_buttons     (display_buttons),
    .player_ready        (player_ready),
    .display_menu_button (display_menu_button)
  );

  background_render background_render_inst (
    .pclk    (pclk),
    .rst     (rst),
    .mode    (mode),
    .vga_in  (timing_bus.sink),
    .vga_out (render_bus.source),
    .rgb     (rgb)
  );

  assign hcount = render_bus.hcount;
  assign vcount = render_bus.vcount;
  assign hsync  = render_bus.hsync;
  assign vsync  = render_bus.vsync;
  assign hblnk  = render_bus.hblnk;
  assign vblnk  = render_bus.vblnk;

endmodule

`default_nettype wire

// ==== hdl/vga_timing.sv ====
`default_nettype none

`include "menu_defines.svh"

module vga_timing (
  input  logic pclk,
  input  logic rst,
  vga_if.source vga
);

  logic [11:0] h_cnt;
  logic [11:0] v_cnt;
  logic [11:0] h_nxt;
  logic [11:0] v_nxt;
  logic        hsync_q;
  logic        vsync_q;
  logic        hblnk_q;
  logic        vblnk_q;

  // Next counter values, wrapping at the end of each line and frame.
  always_comb begin
    if (h_cnt == 12'(`H_TOTAL - 1)) begin
      h_nxt = 12'd0;
      v_nxt = (v_cnt == 12'(`V_TOTAL - 1)) ? 12'd0 : v_cnt + 12'd1;
    end else begin
      h_nxt = h_cnt + 12'd1;
      v_nxt = v_cnt;
    end
  end

  // Flags are decoded from the next counts so they line up with the registered counts.
  always_ff @(posedge pclk) begin
    if (rst) begin
      h_cnt   <= 12'd0;
      v_cnt   <= 12'd0;
      hsync_q <= 1'b0;
      vsync_q <= 1'b0;
      hblnk_q <= 1'b0;
      vblnk_q <= 1'b0;
    end else begin
      h_cnt   <= h_nxt;
      v_cnt   <= v_nxt;
      hblnk_q <= (h_nxt >= 12'(`H_ACTIVE));
      vblnk_q <= (v_nxt >= 12'(`V_ACTIVE));
      hsync_q <= (h_nxt >= 12'(`H_ACTIVE + `H_FRONT)) &&
                 (h_nxt < 12'(`H_ACTIVE + `H_FRONT + `H_SYNC));
      vsync_q <= (v_nxt >= 12'(`V_ACTIVE + `V_FRONT)) &&
                 (v_nxt < 12'(`V_ACTIVE + `V_FRONT + `V_SYNC));
    end
  end

  assign vga.hcount = h_cnt;
  assign vga.vcount = v_cnt;
  assign vga.hsync  = hsync_q;
  assign vga.vsync  = vsync_q;
  assign vga.hblnk  = hblnk_q;
  assign vga.vblnk  = vblnk_q;

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+common
common/menu_pkg.sv
common/vga_if.sv
hdl/vga_timing.sv
hdl/button_decode.sv
background/mode_fsm.sv
background/background_render.sv
hdl/menu_top.sv
tests/menu_sva.sv
tests/menu_check.sv
tests/menu_tb.sv

// ==== tests/menu_check.sv ====
`default_nettype none

`include "menu_defines.svh"

module menu_check (
  input  logic                    pclk,
  input  logic                    rst,
  input  logic [8*16-1:0]         test_name,
  input  logic [11:0]             xpos,
  input  logic [11:0]             ypos,
  input  logic                    mouse_left,
  input  logic                    game_on,
  input  logic                    menu_on,
  input  logic                    game_over,
  input  logic                    victory,
  input  logic                    opponent_ready,
  input  logic [11:0]             hcount,
  input  logic [11:0]             vcount,
  input  logic                    hsync,
  input  logic                    vsync,
  input  logic                    hblnk,
  input  logic                    vblnk,
  input  menu_pkg::rgb_t          rgb,
  input  menu_pkg::screen_mode_e  mode,
  input  logic                    play_selected,
  input  logic                    display_buttons,
  input  logic                    player_ready,
  input  logic                    display_menu_button,
  output int                      mode_errs,
  output int                      timing_errs,
  output int                      pixel_errs
);

  import menu_pkg::*;

  localparam int MAX_REPORTS = 20;

  int mode_cnt = 0;
  int timing_cnt = 0;
  int pixel_cnt = 0;
  int reports = 0;
  bit armed = 1'b0;

  // Model state, updated at each falling edge for the coming rising edge.
  screen_mode_e m_mode = MENU_MODE;
  logic m_play = 1'b0;
  logic m_multi = 1'b0;
  logic m_menu = 1'b0;
  logic m_click = 1'b0;
  int g_h = 0;
  int g_v = 0;
  int o_h = 0;
  int o_v = 0;
  logic [11:0] e_rgb = '0;

  assign mode_errs   = mode_cnt;
  assign timing_errs = timing_cnt;
  assign pixel_errs  = pixel_cnt;

  function automatic bit in_window(input int x, input int y, input int bx, input int by);
    return (x >= bx - 10) && (x <= bx + `BOX_W - 5) && (y >= by - 10) && (y <= by + `BOX_H);
  endfunction

  // Letter rectangles as {x0, x1, y0, y1}, open at x0 and y0.
  function automatic logic [39:0] letter_rect(input int i);
    case (i)
      0:       return {10'd170, 10'd210, 10'd90, 10'd250};
      1:       return {10'd170, 10'd370, 10'd50, 10'd90};
      2:       return {10'd250, 10'd290, 10'd90, 10'd250};
      3:       return {10'd330, 10'd370, 10'd90, 10'd250};
      4:       return {10'd420, 10'd460, 10'd50, 10'd250};
      5:       return {10'd460, 10'd500, 10'd50, 10'd90};
      6:       return {10'd460, 10'd500, 10'd130, 10'd170};
      7:       return {10'd460, 10'd500, 10'd210, 10'd250};
      8:       return {10'd550, 10'd590, 10'd90, 10'd250};
      9:       return {10'd550, 10'd670, 10'd50, 10'd90};
      10:      return {10'd630, 10'd670, 10'd90, 10'd250};
      11:      return {10'd720, 10'd760, 10'd50, 10'd210};
      12:      return {10'd720, 10'd840, 10'd210, 10'd250};
      default: return {10'd800, 10'd840, 10'd50, 10'd210};
    endcase
  endfunction

  function automatic bit menu_letter(input int h, input int v);
    logic [39:0] r;
    bit hit;
    hit = 1'b0;
    for (int i = 0; i < 14; i++) begin
      r = letter_rect(i);
      if (h > int'(r[39:30]) && h <= int'(r[29:20]) && v > int'(r[19:10]) &&
          v <= int'(r[9:0])) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // The frame is the band between the boundary and a rectangle BORDER pixels outside it.
  function automatic bit game_frame(input int h, input int v);
    bit outer;
    bit inner;
    outer = (h >= `LEFT_LINE - `BORDER) && (h < `RIGHT_LINE + `BORDER) &&
            (v >= `TOP_LINE - `BORDER) && (v < `BOTTOM_LINE + `BORDER);
    inner = (h >= `LEFT_LINE) && (h < `RIGHT_LINE) && (v >= `TOP_LINE) && (v < `BOTTOM_LINE);
    return outer && !inner;
  endfunction

  function automatic logic [11:0] ref_rgb(input int h, input int v, input screen_mode_e md);
    if (h >= `H_ACTIVE || v >= `V_ACTIVE) return 12'h000;
    case (md)
      MENU_MODE, GAME_MODE: begin
        if (v == 0) return `EDGE_TOP_RGB;
        if (v == `V_ACTIVE - 1) return `EDGE_BOTTOM_RGB;
        if (h == 0) return `EDGE_LEFT_RGB;
        if (h == `H_ACTIVE - 1) return `EDGE_RIGHT_RGB;
        if (md == MENU_MODE && menu_letter(h, v)) return `LETTER_RGB;
        if (md == GAME_MODE && game_frame(h, v)) return `LETTER_RGB;
        return 12'h000;
      end
      VICTORY_MODE: return `VICTORY_RGB;
      GAME_OVER:    return `OVER_RGB;
      MULTI_WAIT:   return `WAIT_RGB;
      default:      return 12'h000;
    endcase
  endfunction

  function automatic screen_mode_e next_mode(input screen_mode_e cur, input logic hp,
                                             input logic hm, input logic hn, input logic click,
                                             input logic go, input logic mo, input logic ov,
                                             input logic vi, input logic opp);
    screen_mode_e nxt;
    nxt = cur;
    case (cur)
      MENU_MODE: begin
        if (go || hp) nxt = GAME_MODE;
        else if (hm) nxt = MULTI_WAIT;
        else if (ov) nxt = GAME_OVER;
        else if (vi) nxt = VICTORY_MODE;
      end
      GAME_MODE: begin
        if (mo) nxt = MENU_MODE;
        else if (ov) nxt = GAME_OVER;
        else if (vi) nxt = VICTORY_MODE;
      end
      VICTORY_MODE, GAME_OVER: begin
        if (go) nxt = GAME_MODE;
        else if (mo) nxt = MENU_MODE;
        else if (hp) nxt = GAME_MODE;
        else if (hm) nxt = MULTI_WAIT;
        else if (click) nxt = MENU_MODE;
      end
      MULTI_WAIT: begin
        if (hn) nxt = MENU_MODE;
        else if (opp) nxt = GAME_MODE;
      end
      default: nxt = MENU_MODE;
    endcase
    return nxt;
  endfunction

  task automatic check(input int cat, input string sig, input logic [11:0] exp,
                       input logic [11:0] act);
    if (exp !== act) begin
      case (cat)
        0:       mode_cnt = mode_cnt + 1;
        1:       timing_cnt = timing_cnt + 1;
        default: pixel_cnt = pixel_cnt + 1;
      endcase
      if (reports < MAX_REPORTS) begin
        $display("ERR %0s %0s: expected %0h, actual %0h", test_name, sig, exp, act);
      end
      reports = reports + 1;
    end
  endtask

  always @(negedge pclk) begin
    if (armed) begin
      check(0, "mode", 12'(m_mode), 12'(mode));
      check(0, "play_selected", 12'(m_mode == GAME_MODE), 12'(play_selected));
      check(0, "display_buttons", 12'(m_mode == MENU_MODE || m_mode == VICTORY_MODE ||
            m_mode == GAME_OVER), 12'(display_buttons));
      check(0, "player_ready", 12'(m_mode == MULTI_WAIT), 12'(player_ready));
      check(0, "display_menu_button", 12'(m_mode == MULTI_WAIT), 12'(display_menu_button));
      check(1, "hcount", 12'(o_h), hcount);
      check(1, "vcount", 12'(o_v), vcount);
      check(1, "hblnk", 12'(o_h >= `H_ACTIVE), 12'(hblnk));
      check(1, "vblnk", 12'(o_v >= `V_ACTIVE), 12'(vblnk));
      check(1, "hsync", 12'(o_h >= `H_ACTIVE + `H_FRONT &&
            o_h < `H_ACTIVE + `H_FRONT + `H_SYNC), 12'(hsync));
      check(1, "vsync", 12'(o_v >= `V_ACTIVE + `V_FRONT &&
            o_v < `V_ACTIVE + `V_FRONT + `V_SYNC), 12'(vsync));
      check(2, "rgb", e_rgb, rgb);
    end
    if (rst) begin
      m_mode  = MENU_MODE;
      m_play  = 1'b0;
      m_multi = 1'b0;
      m_menu  = 1'b0;
      m_click = 1'b0;
      g_h     = 0;
      g_v     = 0;
      o_h     = 0;
      o_v     = 0;
      e_rgb   = '0;
      armed   = 1'b1;
    end else begin
      // Colour and delayed timing come from the generator counts and the current mode.
      e_rgb = ref_rgb(g_h, g_v, m_mode);
      o_h   = g_h;
      o_v   = g_v;
      if (g_h == `H_TOTAL - 1) begin
        g_h = 0;
        g_v = (g_v == `V_TOTAL - 1) ? 0 : g_v + 1;
      end else begin
        g_h = g_h + 1;
      end
      m_mode = next_mode(m_mode, m_play, m_multi, m_menu, m_click, game_on, menu_on,
                         game_over, victory, opponent_ready);
      m_play  = mouse_left && in_window(int'(xpos), int'(ypos), `PLAY_X, `PLAY_Y);
      m_multi = mouse_left && in_window(int'(xpos), int'(ypos), `MULTI_X, `MULTI_Y);
      m_menu  = mouse_left && in_window(int'(xpos), int'(ypos), `MENU_X, `MENU_Y);
      m_click = mouse_left;
    end
  end

endmodule

`default_nettype wire

// ==== tests/menu_sva.sv ====
`default_nettype none

module menu_sva (
  input  logic                    pclk,
  input  logic                    rst,
  input  menu_pkg::screen_mode_e  mode,
  input  logic                    player_ready,
  input  menu_pkg::rgb_t          rgb,
  input  logic                    hblnk,
  input  logic                    vblnk
);

  import menu_pkg::*;

  int unsigned fail_count = 0;

  // Only the five encoded screen modes may appear.
  mode_legal: assert property (@(posedge pclk) disable iff (rst)
    mode inside {MENU_MODE, GAME_MODE, VICTORY_MODE, GAME_OVER, MULTI_WAIT})
    else begin
      $error("mode holds an encoding outside the screen modes");
      fail_count = fail_count + 1;
    end

  // Delayed blanking and colour leave together, so blanked pixels are black.
  blank_black: assert property (@(posedge pclk) disable iff (rst)
    (hblnk || vblnk) |-> (rgb == '0))
    else begin
      $error("rgb is not black during blanking");
      fail_count = fail_count + 1;
    end

  // The ready flag belongs to the multiplayer wait screen.
  ready_in_wait: assert property (@(posedge pclk) disable iff (rst)
    player_ready |-> (mode == MULTI_WAIT))
    else begin
      $error("player_ready is high outside MULTI_WAIT");
      fail_count = fail_count + 1;
    end

endmodule

`default_nettype wire

// ==== tests/menu_tb.sv ====
`default_nettype none

`include "menu_defines.svh"

module menu_tb;

  import menu_pkg::*;

  localparam int PERIOD = 4;
  localparam int RST_CYCLES = 8;
  localparam int FRAME = `H_TOTAL * `V_TOTAL;
  localparam int MIX_CYCLES = 6000;
  localparam int LINE_TEST = 2 * `H_TOTAL + 400;
  // Directed tests, two lines of pixels, up to two frames of boundary rows, then the mix.
  localparam int RUN_CYCLES = RST_CYCLES + `H_TOTAL + 600 + LINE_TEST + 2 * FRAME + MIX_CYCLES;
  localparam int WATCHDOG_TIME = 2 * RUN_CYCLES * PERIOD;

  // Level input bits in the order game_on, menu_on, game_over, victory, opponent_ready.
  localparam logic [4:0] L_GAME_ON  = 5'b10000;
  localparam logic [4:0] L_MENU_ON  = 5'b01000;
  localparam logic [4:0] L_OVER     = 5'b00100;
  localparam logic [4:0] L_VICTORY  = 5'b00010;
  localparam logic [4:0] L_OPPONENT = 5'b00001;

  logic        pclk;
  logic        rst;
  logic [11:0] xpos;
  logic [11:0] ypos;
  logic        mouse_left;
  logic        game_on;
  logic        menu_on;
  logic        game_over;
  logic        victory;
  logic        opponent_ready;
  logic [11:0] hcount;
  logic [11:0] vcount;
  logic        hsync;
  logic        vsync;
  logic        hblnk;
  logic        vblnk;
  rgb_t        rgb;
  screen_mode_e mode;
  logic        play_selected;
  logic        display_buttons;
  logic        player_ready;
  logic        display_menu_button;
  logic [8*16-1:0] test_name;
  int          mode_errs;
  int          timing_errs;
  int          pixel_errs;
  int          sva_errs;

  menu_top menu_top_inst (
    .pclk (pclk), .rst (rst), .xpos (xpos), .ypos (ypos), .mouse_left (mouse_left),
    .game_on (game_on), .menu_on (menu_on), .game_over (game_over), .victory (victory),
    .opponent_ready (opponent_ready), .hcount (hcount), .vcount (vcount), .hsync (hsync),
    .vsync (vsync), .hblnk (hblnk), .vblnk (vblnk), .rgb (rgb), .mode (mode),
    .play_selected (play_selected), .display_buttons (display_buttons),
    .player_ready (player_ready), .display_menu_button (display_menu_button)
  );

  menu_check menu_check_inst (
    .pclk (pclk), .rst (rst), .test_name (test_name), .xpos (xpos), .ypos (ypos),
    .mouse_left (mouse_left), .game_on (game_on), .menu_on (menu_on),
    .game_over (game_over), .victory (victory), .opponent_ready (opponent_ready),
    .hcount (hcount), .vcount (vcount), .hsync (hsync), .vsync (vsync), .hblnk (hblnk),
    .vblnk (vblnk), .rgb (rgb), .mode (mode), .play_selected (play_selected),
    .display_buttons (display_buttons), .player_ready (player_ready),
    .display_menu_button (display_menu_button), .mode_errs (mode_errs),
    .timing_errs (timing_errs), .pixel_errs (pixel_errs)
  );

  bind menu_top menu_sva sva_inst (
    .pclk (pclk), .rst (rst), .mode (mode), .player_ready (player_ready), .rgb (rgb),
    .hblnk (hblnk), .vblnk (vblnk)
  );

  initial begin
    pclk = 1'b0;
    forever #(PERIOD / 2) pclk = ~pclk;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired: the tests did not finish in the expected time");
    $display("Done: errors found");
    $finish;
  end

  task automatic idle(input int n);
    repeat (n) @(posedge pclk);
  endtask

  task automatic press_at(input int x, input int y);
    @(posedge pclk);
    xpos       <= 12'(x);
    ypos       <= 12'(y);
    mouse_left <= 1'b1;
    @(posedge pclk);
    mouse_left <= 1'b0;
    idle(4);
  endtask

  task automatic pulse_levels(input logic [4:0] lv);
    @(posedge pclk);
    {game_on, menu_on, game_over, victory, opponent_ready} <= lv;
    @(posedge pclk);
    {game_on, menu_on, game_over, victory, opponent_ready} <= 5'b00000;
    idle(3);
  endtask

  // Waits for the delayed timing to reach the start of a row.
  task automatic wait_row(input int row);
    do @(negedge pclk);
    while (!(hcount == 12'd0 && vcount == 12'(row)));
  endtask

  task automatic random_mix(input int n);
    repeat (n) begin
      @(posedge pclk);
      xpos           <= 12'($urandom_range(400, 580));
      ypos           <= 12'($urandom_range(380, 630));
      mouse_left     <= ($urandom_range(0, 3) == 0);
      game_on        <= ($urandom_range(0, 31) == 0);
      menu_on        <= ($urandom_range(0, 31) == 0);
      game_over      <= ($urandom_range(0, 31) == 0);
      victory        <= ($urandom_range(0, 31) == 0);
      opponent_ready <= ($urandom_range(0, 15) == 0);
    end
    @(posedge pclk);
    {mouse_left, game_on, menu_on, game_over, victory, opponent_ready} <= 6'b000000;
  endtask

  initial begin
    rst            = 1'b1;
    xpos           = 12'd0;
    ypos           = 12'd0;
    mouse_left     = 1'b0;
    game_on        = 1'b0;
    menu_on        = 1'b0;
    game_over      = 1'b0;
    victory        = 1'b0;
    opponent_ready = 1'b0;
    test_name      = "reset";
    void'($urandom(32'he4764972));
    repeat (RST_CYCLES) @(posedge pclk);
    rst <= 1'b0;
    idle(`H_TOTAL + 20);

    test_name = "mouse_nav";
    press_at(`PLAY_X - 11, `PLAY_Y);
    press_at(`PLAY_X + `BOX_W - 4, `PLAY_Y);
    press_at(`PLAY_X, `PLAY_Y - 11);
    press_at(`PLAY_X, `PLAY_Y + `BOX_H + 1);
    press_at(`PLAY_X - 10, `PLAY_Y - 10);
    pulse_levels(L_MENU_ON);
    press_at(`MULTI_X + `BOX_W - 5, `MULTI_Y + `BOX_H);
    press_at(`MENU_X + 20, `MENU_Y - 5);

    test_name = "levels";
    pulse_levels(L_OVER);
    press_at(0, 0);
    pulse_levels(L_VICTORY);
    press_at(0, 0);
    pulse_levels(L_OVER | L_VICTORY);
    pulse_levels(L_GAME_ON | L_MENU_ON);
    pulse_levels(L_MENU_ON | L_OVER);
    pulse_levels(L_GAME_ON);
    pulse_levels(L_VICTORY | L_OVER);
    pulse_levels(L_MENU_ON);
    pulse_levels(L_VICTORY);
    press_at(`PLAY_X + 20, `PLAY_Y + 20);
    pulse_levels(L_VICTORY);
    press_at(`MULTI_X + 8, `MULTI_Y + 70);

    test_name = "multi_wait";
    press_at(`PLAY_X + 20, `PLAY_Y + 20);
    pulse_levels(L_GAME_ON | L_OVER);
    pulse_levels(L_OPPONENT);
    pulse_levels(L_MENU_ON);
    press_at(`MULTI_X + 8, `MULTI_Y + 70);
    press_at(`MENU_X + 20, `MENU_Y - 5);

    test_name = "pixels";
    repeat (LINE_TEST / 80) begin
      case ($urandom_range(0, 5))
        0:       pulse_levels(L_GAME_ON);
        1:       pulse_levels(L_MENU_ON);
        2:       pulse_levels(L_OVER);
        3:       pulse_levels(L_VICTORY);
        4:       pulse_levels(L_OPPONENT);
        default: press_at(`MULTI_X + 8, `MULTI_Y + 70);
      endcase
      idle(72);
    end

    // Menu letters on the upper rows, then the game frame, then the frame wrap.
    test_name = "boundary";
    press_at(`MENU_X + 20, `MENU_Y - 5);
    pulse_levels(L_MENU_ON);
    wait_row(`TOP_LINE - `BORDER - 20);
    pulse_levels(L_GAME_ON);
    wait_row(`BOTTOM_LINE + `BORDER + 2);
    wait_row(0);

    test_name = "random_mix";
    random_mix(MIX_CYCLES);
    idle(4);

    @(negedge pclk);
    sva_errs = int'(menu_top_inst.sva_inst.fail_count);
    $display("Error counts: mode %0d, timing %0d, pixel %0d, assertion %0d",
             mode_errs, timing_errs, pixel_errs, sva_errs);
    if (mode_errs + timing_errs + pixel_errs + sva_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
